//--- verilog/snes_cart_pkg.sv
`default_nettype none

package snes_cart_pkg;

	// ==================================================
	// Cartridge layout and enhancement chip codes
	// ==================================================

	typedef enum logic [1:0] {
		map_lo   = 2'd0,
		map_hi   = 2'd1,
		map_exhi = 2'd2
	} map_layout_e;

	// Upper nibble of the rom-type byte
	// st0xx reuses the dsp1 code plus extra bits
	typedef enum logic [3:0] {
		chip_none = 4'h0,
		chip_sdd1 = 4'h5,
		chip_sa1  = 4'h6,
		chip_gsu  = 4'h7,
		chip_dsp1 = 4'h8,
		chip_dsp2 = 4'h9,
		chip_dsp3 = 4'hA,
		chip_dsp4 = 4'hB,
		chip_obc1 = 4'hC
	} cart_chip_e;

	// ==================================================
	// Bundles passed between blocks
	// ==================================================

	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} load_beat_t;

	typedef struct packed {
		logic [7:0] mapper;
		logic [7:0] chip_type;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
		logic [7:0] company;
	} cart_header_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
	} cart_info_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Internal header offsets inside the 32 KiB bank
	localparam logic [14:0] HDR_MAPPER_OFS  = 15'h7FD4;
	localparam logic [14:0] HDR_TYPE_OFS    = 15'h7FD6;
	localparam logic [14:0] HDR_RAM_OFS     = 15'h7FD8;
	localparam logic [14:0] HDR_COMPANY_OFS = 15'h7FDA;

	// 512 byte SD sectors
	localparam int SECTOR_SIZE_LOG2 = 9;
	// Size fields count in 1 KiB units
	localparam int MASK_UNIT_LOG2   = 10;
	// SuperFX carts always get 64 KiB of save RAM
	localparam int GSU_RAM_LOG2     = 6;

endpackage

`default_nettype wire

//--- verilog/header_capture.sv
`timescale 1ns/1ns
`default_nettype none

module header_capture (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire snes_cart_pkg::map_layout_e map_layout,
	input  wire                         download,
	input  wire                         load_strobe,
	input  wire snes_cart_pkg::load_beat_t  load_beat,
	output snes_cart_pkg::cart_header_t     header
);
	import snes_cart_pkg::*;

	logic [8:0] hdr_prefix;
	logic       beat_valid;
	logic       hit_start;
	logic       hit_mapper;
	logic       hit_type;
	logic       hit_ram;
	logic       hit_company;

	// Address bits above 15 where the header lives
	always_comb begin
		case (map_layout)
			map_hi:   hdr_prefix = 9'h001;
			map_exhi: hdr_prefix = {8'h40, 1'b1};
			default:  hdr_prefix = 9'h000;
		endcase
	end

	assign beat_valid  = download && load_strobe;
	assign hit_start   = load_beat.addr == 24'd0;
	assign hit_mapper  = load_beat.addr == {hdr_prefix, HDR_MAPPER_OFS};
	assign hit_type    = load_beat.addr == {hdr_prefix, HDR_TYPE_OFS};
	assign hit_ram     = load_beat.addr == {hdr_prefix, HDR_RAM_OFS};
	assign hit_company = load_beat.addr == {hdr_prefix, HDR_COMPANY_OFS};

	// ==================================================
	// Field capture, one beat per strobe
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			header <= '0;
		end else if (beat_valid) begin
			// New image, forget the previous save size
			if (hit_start) begin
				header.ram_size <= 4'h0;
			end
			// Mapper byte sits in the upper half of the word
			if (hit_mapper) begin
				header.mapper <= load_beat.data[15:8];
			end
			if (hit_type) begin
				{header.rom_size, header.chip_type} <= load_beat.data[11:0];
			end
			if (hit_ram) begin
				header.ram_size <= load_beat.data[3:0];
			end
			if (hit_company) begin
				header.company <= load_beat.data[7:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cart_classify.sv
`timescale 1ns/1ns
`default_nettype none

module cart_classify (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire snes_cart_pkg::map_layout_e   map_layout,
	input  wire                           download,
	input  wire snes_cart_pkg::cart_header_t  header,
	output snes_cart_pkg::cart_info_t         cart_info,
	output logic                          cart_ready
);
	import snes_cart_pkg::*;

	logic        download_q;
	logic        download_fall;
	logic [7:0]  mapper;
	logic [7:0]  chip_type;
	logic [4:0]  rom_shift;
	logic [23:0] rom_mask_next;
	logic [23:0] ram_mask_next;
	cart_chip_e  chip;
	logic        st_flag;
	logic        st_small;
	logic        gsu_ram;
	logic [3:0]  chip_nib;

	assign download_fall = download_q && !download;
	assign mapper        = header.mapper;
	assign chip_type     = header.chip_type;

	// Small ROMs are rounded up to 4 MiB
	assign rom_shift     = (header.rom_size < 4'd7) ? 5'd12 : {1'b0, header.rom_size};
	assign rom_mask_next = (24'd1 << (MASK_UNIT_LOG2 + rom_shift)) - 24'd1;
	assign ram_mask_next = (header.ram_size == 4'd0) ? 24'd0 :
		(24'd1 << (MASK_UNIT_LOG2 + header.ram_size)) - 24'd1;

	// ==================================================
	// Enhancement chip rules, first match wins
	// ==================================================

	always_comb begin
		chip     = chip_none;
		st_flag  = 1'b0;
		st_small = 1'b0;
		gsu_ram  = 1'b0;
		if (mapper == 8'h30 && chip_type == 8'h05 && header.company == 8'hB2) begin
			chip = chip_dsp3;
		end else if (((mapper == 8'h20 || mapper == 8'h21) && chip_type == 8'h03) ||
				(mapper == 8'h30 && chip_type == 8'h05) ||
				(mapper == 8'h31 && (chip_type == 8'h03 || chip_type == 8'h05))) begin
			chip = chip_dsp1;
		end else if (mapper == 8'h20 && chip_type == 8'h05) begin
			chip = chip_dsp2;
		end else if (mapper == 8'h30 && chip_type == 8'h03) begin
			chip = chip_dsp4;
		end else if (mapper == 8'h30 && chip_type == 8'h25) begin
			chip = chip_obc1;
		end else if (mapper == 8'h32 && (chip_type == 8'h43 || chip_type == 8'h45)) begin
			chip = chip_sdd1;
		end else if (mapper == 8'h30 && chip_type == 8'hF6) begin
			// Seta st0xx, smaller boards flagged in bit 5
			chip     = chip_dsp1;
			st_flag  = 1'b1;
			st_small = header.rom_size < 4'd10;
		end else if (mapper == 8'h20 && (chip_type == 8'h13 || chip_type == 8'h14 ||
				chip_type == 8'h15 || chip_type == 8'h1A)) begin
			chip    = chip_gsu;
			gsu_ram = 1'b1;
		end else if (mapper == 8'h23 && (chip_type == 8'h32 || chip_type == 8'h34 ||
				chip_type == 8'h35)) begin
			chip = chip_sa1;
		end
	end

	assign chip_nib = chip | {2'b00, st_small, 1'b0};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			download_q <= download;
			if (download && !download_q) begin
				cart_ready <= 1'b0;
			end else if (download_fall) begin
				cart_ready <= 1'b1;
			end
		end
	end

	// Result latched once the whole image is in
	always_ff @(posedge clk_sys) begin
		if (download_fall) begin
			cart_info.rom_type <= {chip_nib, st_flag, 1'b0, map_layout};
			cart_info.rom_mask <= rom_mask_next;
			cart_info.ram_mask <= gsu_ram ?
				(24'd1 << (MASK_UNIT_LOG2 + GSU_RAM_LOG2)) - 24'd1 : ram_mask_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/backup_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module backup_sequencer (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  download,
	input  wire                  img_mounted,
	input  wire [31:0]           img_size,
	input  wire                  save_strobe,
	input  wire                  sd_ack,
	output snes_cart_pkg::sd_req_t sd_req,
	output logic                 load_start,
	output logic                 save_start,
	output logic                 loading,
	output logic                 backup_busy
);
	import snes_cart_pkg::*;

	typedef enum logic {
		st_idle,
		st_xfer
	} seq_state_e;

	seq_state_e                   state;
	logic                         enable;
	logic                         load_pend;
	logic [20-SECTOR_SIZE_LOG2:0] limit;
	logic                         sd_ack_q;
	logic                         download_q;

	assign backup_busy = state == st_xfer;

	// ==================================================
	// Mount tracking and sector loop
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= st_idle;
			enable     <= 1'b0;
			load_pend  <= 1'b0;
			loading    <= 1'b0;
			load_start <= 1'b0;
			save_start <= 1'b0;
			sd_ack_q   <= 1'b0;
			download_q <= 1'b0;
			sd_req.rd  <= 1'b0;
			sd_req.wr  <= 1'b0;
		end else begin
			sd_ack_q   <= sd_ack;
			download_q <= download;
			load_start <= 1'b0;
			save_start <= 1'b0;

			// Host took the request
			if (sd_ack && !sd_ack_q) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (enable && (load_pend || save_strobe)) begin
						state      <= st_xfer;
						sd_req.lba <= 32'd0;
						sd_req.rd  <= load_pend;
						sd_req.wr  <= !load_pend;
						loading    <= load_pend;
						load_start <= load_pend;
						save_start <= !load_pend;
						load_pend  <= 1'b0;
					end
				end
				st_xfer: begin
					// Sector done on ack fall
					if (sd_ack_q && !sd_ack) begin
						if (sd_req.lba == 32'(limit)) begin
							state   <= st_idle;
							loading <= 1'b0;
						end else begin
							sd_req.lba <= sd_req.lba + 32'd1;
							sd_req.rd  <= loading;
							sd_req.wr  <= !loading;
						end
					end
				end
				default: state <= st_idle;
			endcase

			// Size zero means the save image was unmounted
			if (img_mounted) begin
				if (|img_size) begin
					enable    <= 1'b1;
					load_pend <= 1'b1;
					limit     <= img_size[20:SECTOR_SIZE_LOG2];
				end else begin
					enable <= 1'b0;
				end
			end

			if (download && !download_q) begin
				enable <= 1'b0;
			end
		end
	end

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr));

	// A fresh transfer only starts from an enabled idle state
	a_req_needs_enable: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_req.rd || sd_req.wr) && !$past(backup_busy) |-> $past(enable));

endmodule

`default_nettype wire

//--- verilog/sector_word_packer.sv
`timescale 1ns/1ns
`default_nettype none

module sector_word_packer #(
	parameter int BSRAM_AW = 10
) (
	input  wire                                       clk_sys,
	input  wire                                       reset,
	input  wire                                       load_start,
	input  wire                                       save_start,
	input  wire                                       loading,
	input  wire [snes_cart_pkg::SECTOR_SIZE_LOG2-1:0] sd_buff_addr,
	input  wire [7:0]                                 sd_buff_dout,
	input  wire                                       sd_buff_wr,
	input  wire                                       sd_buff_rd,
	output logic [7:0]                                sd_buff_din,
	output logic [BSRAM_AW-1:0]                       ram_addr,
	output logic [15:0]                               ram_wdata,
	output logic                                      ram_we,
	input  wire [15:0]                                ram_rdata
);

	logic [7:0]  low_byte;
	logic [15:0] save_word;

	// Word counter doubles as the RAM address
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_addr <= '0;
			ram_we   <= 1'b0;
		end else begin
			ram_we <= loading && sd_buff_wr && sd_buff_addr[0];
			if (load_start || save_start) begin
				ram_addr <= '0;
			end else if (ram_we || (sd_buff_rd && sd_buff_addr[0])) begin
				ram_addr <= ram_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		// Load side, low byte first
		if (sd_buff_wr) begin
			if (sd_buff_addr[0]) begin
				ram_wdata <= {sd_buff_dout, low_byte};
			end else begin
				low_byte <= sd_buff_dout;
			end
		end
		// Save side, hold the word across its odd byte
		if (!sd_buff_addr[0]) begin
			save_word <= ram_rdata;
		end
	end

	assign sd_buff_din = sd_buff_addr[0] ? save_word[15:8] : save_word[7:0];

	a_we_only_on_load: assert property (@(posedge clk_sys) disable iff (reset)
		ram_we |-> loading);

endmodule

`default_nettype wire

//--- verilog/bsram_store.sv
`timescale 1ns/1ns
`default_nettype none

module bsram_store #(
	parameter int BSRAM_AW = 10
) (
	input  wire                clk_sys,
	input  wire [BSRAM_AW-1:0] addr,
	input  wire [15:0]         wdata,
	input  wire                we,
	output logic [15:0]        rdata
);

	// ==================================================
	// Backup RAM, one port, 16 bit words
	// ==================================================

	logic [15:0] mem [0:(1 << BSRAM_AW)-1];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		// Old data on a same-address write
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- verilog/snes_cart_top.sv
`timescale 1ns/1ns
`default_nettype none

module snes_cart_top #(
	parameter int BSRAM_AW = 10
) (
	input  wire                                       clk_sys,
	input  wire                                       reset,
	input  wire snes_cart_pkg::map_layout_e           map_layout,
	input  wire                                       download,
	input  wire                                       load_strobe,
	input  wire snes_cart_pkg::load_beat_t            load_beat,
	input  wire                                       img_mounted,
	input  wire [31:0]                                img_size,
	input  wire                                       save_strobe,
	input  wire                                       sd_ack,
	input  wire [snes_cart_pkg::SECTOR_SIZE_LOG2-1:0] sd_buff_addr,
	input  wire [7:0]                                 sd_buff_dout,
	input  wire                                       sd_buff_wr,
	input  wire                                       sd_buff_rd,
	output wire snes_cart_pkg::cart_info_t            cart_info,
	output wire                                       cart_ready,
	output wire snes_cart_pkg::sd_req_t               sd_req,
	output wire [7:0]                                 sd_buff_din,
	output wire                                       backup_busy
);
	import snes_cart_pkg::*;

	cart_header_t        header;
	wire                 load_start;
	wire                 save_start;
	wire                 loading;
	wire [BSRAM_AW-1:0]  ram_addr;
	wire [15:0]          ram_wdata;
	wire                 ram_we;
	wire [15:0]          ram_rdata;

	// ==================================================
	// Cartridge detection
	// ==================================================

	header_capture i_header_capture (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.map_layout  (map_layout),
		.download    (download),
		.load_strobe (load_strobe),
		.load_beat   (load_beat),
		.header      (header)
	);

	cart_classify i_cart_classify (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.map_layout (map_layout),
		.download   (download),
		.header     (header),
		.cart_info  (cart_info),
		.cart_ready (cart_ready)
	);

	// ==================================================
	// Backup RAM path
	// ==================================================

	backup_sequencer i_backup_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.save_strobe (save_strobe),
		.sd_ack      (sd_ack),
		.sd_req      (sd_req),
		.load_start  (load_start),
		.save_start  (save_start),
		.loading     (loading),
		.backup_busy (backup_busy)
	);

	sector_word_packer #(.BSRAM_AW(BSRAM_AW)) i_sector_word_packer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.load_start   (load_start),
		.save_start   (save_start),
		.loading      (loading),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_rd   (sd_buff_rd),
		.sd_buff_din  (sd_buff_din),
		.ram_addr     (ram_addr),
		.ram_wdata    (ram_wdata),
		.ram_we       (ram_we),
		.ram_rdata    (ram_rdata)
	);

	bsram_store #(.BSRAM_AW(BSRAM_AW)) i_bsram_store (
		.clk_sys (clk_sys),
		.addr    (ram_addr),
		.wdata   (ram_wdata),
		.we      (ram_we),
		.rdata   (ram_rdata)
	);

endmodule

`default_nettype wire

//--- tb/tb_cart_model.svh
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

// ==================================================
// Reference model of cartridge detection
// ==================================================

// Size fields count 1 KiB units, ROMs below size 7 count as 4 MiB
function automatic logic [23:0] model_rom_mask(input logic [3:0] rom_size);
	int unsigned shift;
	logic [31:0] span;
	shift = (rom_size < 4'd7) ? 12 : rom_size;
	span  = 32'd1 << (10 + shift);
	return 24'(span - 32'd1);
endfunction

// SuperFX boards always carry 64 KiB of save RAM
function automatic logic [23:0] model_ram_mask(input logic [3:0] ram_size,
		input logic [7:0] rom_type);
	logic [31:0] span;
	if (rom_type[7:4] == 4'h7) begin
		return 24'h00_FFFF;
	end
	if (ram_size == 4'd0) begin
		return 24'h0;
	end
	span = 32'd1 << (10 + ram_size);
	return 24'(span - 32'd1);
endfunction

// Chip rules in priority order, first hit decides
function automatic logic [7:0] model_rom_type(input logic [7:0] mapper,
		input logic [7:0] ctype, input logic [7:0] company,
		input logic [3:0] rom_size, input logic [1:0] layout);
	logic [3:0] nib;
	logic       st;
	nib = 4'h0;
	st  = 1'b0;
	if (mapper == 8'h30 && ctype == 8'h05 && company == 8'hB2) begin
		nib = 4'hA;
	end else if ((mapper == 8'h20 && ctype == 8'h03) || (mapper == 8'h21 && ctype == 8'h03) ||
			(mapper == 8'h30 && ctype == 8'h05) ||
			(mapper == 8'h31 && (ctype == 8'h03 || ctype == 8'h05))) begin
		nib = 4'h8;
	end else if (mapper == 8'h20 && ctype == 8'h05) begin
		nib = 4'h9;
	end else if (mapper == 8'h30 && ctype == 8'h03) begin
		nib = 4'hB;
	end else if (mapper == 8'h30 && ctype == 8'h25) begin
		nib = 4'hC;
	end else if (mapper == 8'h32 && (ctype == 8'h43 || ctype == 8'h45)) begin
		nib = 4'h5;
	end else if (mapper == 8'h30 && ctype == 8'hF6) begin
		// Byte bit 5 marks the small Seta boards
		nib = (rom_size < 4'd10) ? 4'hA : 4'h8;
		st  = 1'b1;
	end else if (mapper == 8'h20 && (ctype == 8'h13 || ctype == 8'h14 ||
			ctype == 8'h15 || ctype == 8'h1A)) begin
		nib = 4'h7;
	end else if (mapper == 8'h23 && (ctype == 8'h32 || ctype == 8'h34 || ctype == 8'h35)) begin
		nib = 4'h6;
	end
	return {nib, st, 1'b0, layout};
endfunction

`endif

//--- tb/tb_snes_cart.sv
`timescale 1ns/1ns
`default_nettype none

module tb_snes_cart;
	import snes_cart_pkg::*;

	`include "tb_cart_model.svh"

	localparam int CLK_PERIOD    = 40;
	localparam int N_MASK        = 40;
	localparam int N_CLASS       = 60;
	localparam int DL_CYCLES     = 30;
	localparam int MAX_SECTORS   = 4;
	localparam int SECTOR_CYCLES = 512 * 5 + 20;
	localparam int IDLE_CHECK    = 200;
	// Load, save and the reload before the download check
	localparam int RUN_CYCLES = 2 * (N_MASK + N_CLASS) * DL_CYCLES +
		3 * MAX_SECTORS * SECTOR_CYCLES + 2 * IDLE_CHECK + 500;

	logic        clk_sys;
	logic        reset;
	map_layout_e map_layout;
	logic        download;
	logic        load_strobe;
	load_beat_t  load_beat;
	logic        img_mounted;
	logic [31:0] img_size;
	logic        save_strobe;
	logic        sd_ack;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout;
	logic        sd_buff_wr;
	logic        sd_buff_rd;
	cart_info_t  cart_info;
	logic        cart_ready;
	sd_req_t     sd_req;
	logic [7:0]  sd_buff_din;
	logic        backup_busy;

	logic [31:0] rng_state = 32'hedb2_a2b8;
	// Bytes the host handed over during the last load
	logic [7:0]  image [0:MAX_SECTORS*512-1];
	int          rd_count;
	int          wr_count;
	int          errors;

	snes_cart_top #(.BSRAM_AW(10)) i_snes_cart_top (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("error %s got %h expected %h", name, got, expected);
			abort_run();
		end
	endtask

	// ==================================================
	// Download side
	// ==================================================

	task automatic send_beat(input logic [23:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		load_strobe <= 1'b1;
		load_beat   <= {addr, data};
		@(posedge clk_sys);
		load_strobe <= 1'b0;
	endtask

	task automatic run_download(input logic [1:0] layout, input logic [7:0] mapper,
			input logic [7:0] ctype, input logic [7:0] company,
			input logic [3:0] rom_size, input logic [3:0] ram_size);
		logic [23:0] base;
		logic [31:0] r;
		logic        with_ram;
		logic [7:0]  rom_type;
		base     = (layout == 2'd1) ? 24'h00_8000 : (layout == 2'd2) ? 24'h40_8000 : 24'h0;
		r        = next_random();
		with_ram = r[4];
		@(posedge clk_sys);
		map_layout <= map_layout_e'(layout);
		download   <= 1'b1;
		send_beat(24'h0, r[15:0]);
		send_beat(base | 24'h7FD4, {mapper, r[23:16]});
		send_beat(base | 24'h7FD6, {r[27:24], rom_size, ctype});
		// Same offset in the other bank must be ignored
		send_beat((base ^ 24'h00_8000) | 24'h7FD6, r[31:16]);
		// Without a ram beat the size from the last image must be gone
		if (with_ram) begin
			send_beat(base | 24'h7FD8, {r[31:20], ram_size});
		end
		send_beat(base | 24'h7FDA, {r[31:24], company});
		@(posedge clk_sys);
		download <= 1'b0;
		@(negedge clk_sys);
		while (!cart_ready) begin
			@(negedge clk_sys);
		end
		rom_type = model_rom_type(mapper, ctype, company, rom_size, layout);
		check_value("cart_info.rom_type", cart_info.rom_type, rom_type);
		check_value("cart_info.rom_mask", cart_info.rom_mask, model_rom_mask(rom_size));
		check_value("cart_info.ram_mask", cart_info.ram_mask,
			model_ram_mask(with_ram ? ram_size : 4'h0, rom_type));
	endtask

	// Steers headers towards each chip rule and its near misses
	task automatic pick_chip_header(output logic [7:0] mapper, output logic [7:0] ctype,
			output logic [7:0] company);
		logic [31:0] r;
		r       = next_random();
		company = r[31:24];
		mapper  = r[15:8];
		ctype   = r[23:16];
		case (r[7:0] % 8'd12)
			8'd0: begin
				mapper  = 8'h30;
				ctype   = 8'h05;
				// A company one bit off turns dsp3 into dsp1
				company = r[8] ? 8'hB2 : 8'hB2 ^ (8'h01 << r[11:9]);
			end
			8'd1: begin
				mapper = r[8] ? 8'h31 : {7'h10, r[9]};
				ctype  = (r[8] && r[10]) ? 8'h05 : 8'h03;
			end
			8'd2: begin
				mapper = 8'h20;
				ctype  = 8'h05;
			end
			8'd3: begin
				mapper = 8'h30;
				ctype  = 8'h03;
			end
			8'd4: begin
				mapper = 8'h30;
				ctype  = 8'h25;
			end
			8'd5: begin
				mapper = 8'h32;
				ctype  = r[8] ? 8'h45 : 8'h43;
			end
			8'd6: begin
				mapper = 8'h30;
				ctype  = 8'hF6;
			end
			8'd7: begin
				mapper = 8'h20;
				ctype  = (r[9:8] == 2'd3) ? 8'h1A : 8'h13 + {6'h0, r[9:8]};
			end
			8'd8: begin
				mapper = 8'h23;
				ctype  = (r[9:8] == 2'd0) ? 8'h32 : (r[9:8] == 2'd1) ? 8'h34 : 8'h35;
			end
			// One bit off in the mapper or in the type
			8'd9: begin
				mapper = 8'h30 ^ (8'h01 << r[10:8]);
				ctype  = r[11] ? 8'h05 : 8'h25;
			end
			8'd10: begin
				mapper = 8'h20;
				ctype  = 8'h13 ^ (8'h01 << r[10:8]);
			end
			default: begin
			end
		endcase
	endtask

	// ==================================================
	// SD host and backup transfers
	// ==================================================

	task automatic serve_sector(input int sector);
		logic       is_read;
		logic [7:0] b;
		int         delay;
		is_read = sd_req.rd;
		check_value("sd_req.lba", sd_req.lba, sector);
		if (is_read) begin
			rd_count++;
		end else begin
			wr_count++;
		end
		delay = 1 + int'(next_random() % 8);
		repeat (delay) @(posedge clk_sys);
		sd_ack <= 1'b1;
		for (int a = 0; a < 512; a++) begin
			if (is_read) begin
				b = 8'(next_random());
				image[sector * 512 + a] = b;
				@(posedge clk_sys);
				sd_buff_addr <= 9'(a);
				sd_buff_dout <= b;
				sd_buff_wr   <= 1'b1;
				@(posedge clk_sys);
				sd_buff_wr <= 1'b0;
			end else begin
				@(posedge clk_sys);
				sd_buff_rd   <= 1'b0;
				sd_buff_addr <= 9'(a);
				// Data is valid two cycles after the address moves
				repeat (2) @(posedge clk_sys);
				@(negedge clk_sys);
				check_value("sd_buff_din", sd_buff_din, image[sector * 512 + a]);
				@(posedge clk_sys);
				sd_buff_rd <= 1'b1;
			end
		end
		@(posedge clk_sys);
		sd_buff_rd <= 1'b0;
		sd_ack     <= 1'b0;
	endtask

	initial begin : sd_host
		int sector;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_rd   = 1'b0;
		rd_count     = 0;
		wr_count     = 0;
		sector       = 0;
		forever begin
			@(negedge clk_sys);
			if (!backup_busy) begin
				sector = 0;
			end
			if (!reset && (sd_req.rd || sd_req.wr)) begin
				serve_sector(sector);
				sector++;
			end
		end
	end

	task automatic mount_image(input logic [31:0] size);
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		img_size    <= size;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
	endtask

	task automatic pulse_save();
		@(posedge clk_sys);
		save_strobe <= 1'b1;
		@(posedge clk_sys);
		save_strobe <= 1'b0;
	endtask

	task automatic run_transfer(input logic is_save, input logic [31:0] size, input int sectors);
		int rd_base;
		int wr_base;
		rd_base = rd_count;
		wr_base = wr_count;
		if (is_save) begin
			pulse_save();
		end else begin
			mount_image(size);
		end
		@(negedge clk_sys);
		while (!backup_busy) begin
			@(negedge clk_sys);
		end
		while (backup_busy) begin
			@(negedge clk_sys);
		end
		check_value("sd_req.rd requests", rd_count - rd_base, is_save ? 0 : sectors);
		check_value("sd_req.wr requests", wr_count - wr_base, is_save ? sectors : 0);
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk_sys);
			check_value("sd_req.rd", sd_req.rd, 0);
			check_value("sd_req.wr", sd_req.wr, 0);
			check_value("backup_busy", backup_busy, 0);
		end
	endtask

	initial begin : watchdog
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout, the tests did not finish in the expected time");
		abort_run();
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin : main_seq
		logic [31:0] r;
		logic [31:0] size;
		logic [7:0]  mapper;
		logic [7:0]  ctype;
		logic [7:0]  company;
		int          sectors;
		errors      = 0;
		reset       = 1'b1;
		map_layout  = map_lo;
		download    = 1'b0;
		load_strobe = 1'b0;
		load_beat   = '0;
		img_mounted = 1'b0;
		img_size    = '0;
		save_strobe = 1'b0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_value("sd_req.rd", sd_req.rd, 0);
		check_value("sd_req.wr", sd_req.wr, 0);
		check_value("backup_busy", backup_busy, 0);
		check_value("cart_ready", cart_ready, 0);

		// Plain boards without a chip
		for (int i = 0; i < N_MASK; i++) begin
			r = next_random();
			run_download(r[9:8] % 2'd3, {7'h10, r[0]}, r[1] ? 8'h02 : 8'h00, r[31:24],
				r[15:12], r[19:16]);
		end

		// Seta boards on both sides of the size boundary
		run_download(2'd0, 8'h30, 8'hF6, 8'h00, 4'd9, 4'd1);
		run_download(2'd1, 8'h30, 8'hF6, 8'h00, 4'd10, 4'd1);
		for (int i = 2; i < N_CLASS; i++) begin
			r = next_random();
			pick_chip_header(mapper, ctype, company);
			run_download(r[9:8] % 2'd3, mapper, ctype, company, r[15:12], r[19:16]);
		end

		// Image of 1 to 4 sectors with the limit in size bits 20 to 9
		r       = next_random();
		sectors = int'(r[1:0]) + 1;
		size    = {21'h0, r[1:0], 9'h000} + 32'd1 + (r[31:16] % 32'd511);
		run_transfer(1'b0, size, sectors);
		run_transfer(1'b1, size, sectors);

		// Unmounted image blocks saves
		mount_image(32'd0);
		pulse_save();
		check_idle(IDLE_CHECK);

		// So does a new ROM download
		run_transfer(1'b0, size, sectors);
		@(posedge clk_sys);
		download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		pulse_save();
		check_idle(IDLE_CHECK);
		@(posedge clk_sys);
		download <= 1'b0;
		repeat (4) @(posedge clk_sys);

		if (errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+tb
verilog/snes_cart_pkg.sv
verilog/header_capture.sv
verilog/cart_classify.sv
verilog/backup_sequencer.sv
verilog/sector_word_packer.sv
verilog/bsram_store.sv
verilog/snes_cart_top.sv
tb/tb_snes_cart.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the cartridge testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_snes_cart -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_snes_cart > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
